//--- source/shell_defs.svh
`ifndef SHELL_DEFS_SVH
`define SHELL_DEFS_SVH

// ==============================
// ROM store geometry
// ==============================

// Word address width of the ROM store
`define SHELL_ROM_AW 12
// Write FIFO depth, also the number of credits held after reset
`define SHELL_ROM_CREDITS 4
// Cycles between refresh stalls, each stall lasts 2 cycles
`define SHELL_REFRESH_PERIOD 64

// Audio sample width
`define SHELL_DAC_WIDTH 16

// ==============================
// Status word bit positions
// ==============================
`define SHELL_OPT_RESET 0
`define SHELL_OPT_ROTATE 2
`define SHELL_OPT_SCAN_LO 3
`define SHELL_OPT_JOYSWAP 6
`define SHELL_OPT_SERVICE 8
`define SHELL_OPT_DSW1_LO 16
`define SHELL_OPT_DSW2_LO 24

`endif

//--- source/shell_pkg.sv
`default_nettype none

`include "shell_defs.svh"

package shell_pkg;

	// Download stream as it comes from the control processor
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  dout;
	} ioctl_t;

	// One word write into the ROM store
	typedef struct packed {
		logic                     valid;
		logic [`SHELL_ROM_AW-1:0] addr;
		logic [15:0]              data;
	} rom_wr_t;

	// Player port byte, all bits active low as the core expects them
	typedef struct packed {
		logic       start;
		logic [2:0] fire;
		logic       right;
		logic       left;
		logic       down;
		logic       up;
	} player_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
		logic       hs;
		logic       vs;
		logic       hb;
		logic       vb;
	} core_video_t;

	// Sync lines here are already inverted for the board
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
		logic       hs_n;
		logic       vs_n;
	} board_video_t;

endpackage

`default_nettype wire

//--- source/download_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "shell_defs.svh"

module download_ctrl (
	input  wire                       clk_72,
	input  wire                       arst_n,
	input  wire shell_pkg::ioctl_t    ioctl,
	input  wire                       status_reset,
	input  wire                       button_reset,
	input  wire                       credit,
	output shell_pkg::rom_wr_t        rom_wr,
	output logic                      rom_loaded,
	output logic                      core_reset
);

	localparam int AW = `SHELL_ROM_AW;
	localparam int CRED_W = $clog2(`SHELL_ROM_CREDITS + 1);

	logic [7:0]        lo_byte;
	logic [AW-1:0]     q_addr [2];
	logic [15:0]       q_data [2];
	logic [1:0]        q_count;
	logic [CRED_W-1:0] credits;
	logic              download_d;
	logic              rom_dl;
	logic              word_done;
	logic              send;

	// Only index 0 carries the ROM image
	assign rom_dl    = ioctl.download && (ioctl.index == 8'd0);
	assign word_done = rom_dl && ioctl.wr && ioctl.addr[0];

	// A queued word goes out as soon as a credit is available
	assign send   = (q_count != 2'd0) && (credits != '0);
	assign rom_wr = '{valid: send, addr: q_addr[0], data: q_data[0]};

	// ==============================
	// Byte packing and hold queue
	// ==============================
	always_ff @(posedge clk_72) begin
		if (rom_dl && ioctl.wr && !ioctl.addr[0]) begin
			lo_byte <= ioctl.dout;
		end
	end

	// Entry 0 is the head; a pop shifts entry 1 down
	always_ff @(posedge clk_72) begin
		if (send) begin
			q_addr[0] <= q_addr[1];
			q_data[0] <= q_data[1];
		end
		if (word_done) begin
			if (q_count == 2'd0 || (q_count == 2'd1 && send)) begin
				q_addr[0] <= ioctl.addr[AW:1];
				q_data[0] <= {ioctl.dout, lo_byte};
			end else begin
				q_addr[1] <= ioctl.addr[AW:1];
				q_data[1] <= {ioctl.dout, lo_byte};
			end
		end
	end

	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			q_count <= 2'd0;
			credits <= CRED_W'(`SHELL_ROM_CREDITS);
		end else begin
			q_count <= q_count + {1'b0, word_done} - {1'b0, send};
			credits <= credits + CRED_W'(credit) - CRED_W'(send);
		end
	end

	// ==============================
	// ROM loaded flag and core reset
	// ==============================
	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_d <= ioctl.download;
			if (download_d && !ioctl.download && ioctl.index == 8'd0) begin
				rom_loaded <= 1'b1;
			end
			core_reset <= status_reset | button_reset | ~rom_loaded | ioctl.download;
		end
	end

endmodule

`default_nettype wire

//--- source/rom_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "shell_defs.svh"

module rom_store (
	input  wire                       clk_72,
	input  wire                       arst_n,
	input  wire shell_pkg::rom_wr_t   rom_wr,
	output logic                      credit,
	input  wire [`SHELL_ROM_AW-1:0]   rd_addr,
	output logic [15:0]               rd_data
);

	localparam int AW = `SHELL_ROM_AW;
	localparam int DEPTH = `SHELL_ROM_CREDITS;
	localparam int PW = $clog2(DEPTH);
	localparam int CW = PW + 1;
	localparam int RW = $clog2(`SHELL_REFRESH_PERIOD);

	logic [AW-1:0] f_addr [DEPTH];
	logic [15:0]   f_data [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] f_count;
	logic [RW-1:0] refresh_cnt;
	logic          stall;
	logic          drain;
	logic [15:0]   mem [2**AW];

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// The first two counts of every refresh period stand for the SDRAM refresh
	assign stall = refresh_cnt < RW'(2);
	assign drain = (f_count != '0) && !stall;

	always_ff @(posedge clk_72) begin
		if (rom_wr.valid) begin
			f_addr[wr_ptr] <= rom_wr.addr;
			f_data[wr_ptr] <= rom_wr.data;
		end
		if (drain) begin
			mem[f_addr[rd_ptr]] <= f_data[rd_ptr];
		end
		rd_data <= mem[rd_addr];
	end

	// Credit rises with the memory write, one pulse per retired entry
	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			f_count     <= '0;
			refresh_cnt <= '0;
			credit      <= 1'b0;
		end else begin
			if (rom_wr.valid) wr_ptr <= next_ptr(wr_ptr);
			if (drain) rd_ptr <= next_ptr(rd_ptr);
			f_count     <= f_count + CW'(rom_wr.valid) - CW'(drain);
			refresh_cnt <= (refresh_cnt == RW'(`SHELL_REFRESH_PERIOD - 1)) ? '0 : refresh_cnt + 1'b1;
			credit      <= drain;
		end
	end

endmodule

`default_nettype wire

//--- source/input_mapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "shell_defs.svh"

module input_mapper (
	input  wire                 clk_72,
	input  wire                 arst_n,
	input  wire [31:0]          joystick_0,
	input  wire [31:0]          joystick_1,
	input  wire [63:0]          status,
	output shell_pkg::player_t  p1,
	output shell_pkg::player_t  p2,
	output logic [15:0]         coin,
	output logic [7:0]          dsw1,
	output logic [6:0]          dsw2
);

	logic [31:0] stick_1;
	logic [31:0] stick_2;
	logic        rotate;
	logic        joyswap;
	logic        service;
	logic        tilt;

	// Joystick bits 0 right, 1 left, 2 down, 3 up, 4..6 fire, 8 start
	function automatic shell_pkg::player_t map_player(input logic [31:0] joy, input logic rot);
		logic [3:0]         dirs;
		shell_pkg::player_t p;
		// Quarter turn clockwise keeps the joystick bit order
		dirs    = rot ? {joy[1], joy[0], joy[2], joy[3]} : joy[3:0];
		p.start = ~joy[8];
		p.fire  = ~joy[6:4];
		p.right = ~dirs[0];
		p.left  = ~dirs[1];
		p.down  = ~dirs[2];
		p.up    = ~dirs[3];
		return p;
	endfunction

	assign rotate  = status[`SHELL_OPT_ROTATE];
	assign joyswap = status[`SHELL_OPT_JOYSWAP];
	assign service = status[`SHELL_OPT_SERVICE];

	assign stick_1 = joyswap ? joystick_1 : joystick_0;
	assign stick_2 = joyswap ? joystick_0 : joystick_1;
	assign tilt    = stick_1[10] | stick_2[10];

	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			p1   <= '1;
			p2   <= '1;
			coin <= '1;
			dsw1 <= '1;
			dsw2 <= '1;
		end else begin
			p1   <= map_player(stick_1, rotate);
			p2   <= map_player(stick_2, rotate);
			// Test button belongs to player 1, coins are bit 9 of each stick
			coin <= {11'h7ff, ~tilt, ~service, ~stick_1[7], ~stick_1[9], ~stick_2[9]};
			dsw1 <= ~status[`SHELL_OPT_DSW1_LO +: 8];
			dsw2 <= ~status[`SHELL_OPT_DSW2_LO +: 7];
		end
	end

endmodule

`default_nettype wire

//--- source/video_out.sv
`timescale 1ns/1ps
`default_nettype none

module video_out (
	input  wire                          clk_72,
	input  wire                          arst_n,
	input  wire shell_pkg::core_video_t  core_video,
	input  wire [1:0]                    scanlines,
	output shell_pkg::board_video_t      board_video
);

	logic hs_d;
	logic vs_d;
	logic line_odd;
	logic blank;

	// Floor of c * (4 - s) / 4 where s = 0 leaves the colour as it is
	function automatic logic [3:0] dim(input logic [3:0] c, input logic [1:0] s);
		logic [5:0] prod;
		prod = {2'b00, c} * (6'd4 - {4'b0000, s});
		return prod[5:2];
	endfunction

	assign blank = core_video.hb | core_video.vb;

	// ==============================
	// Line counter
	// ==============================

	// Only the parity of the line number matters for dimming
	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			hs_d     <= 1'b0;
			vs_d     <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hs_d <= core_video.hs;
			vs_d <= core_video.vs;
			if (core_video.vs && !vs_d) begin
				line_odd <= 1'b0;
			end else if (core_video.hs && !hs_d) begin
				line_odd <= ~line_odd;
			end
		end
	end

	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			board_video <= '{r: 4'd0, g: 4'd0, b: 4'd0, hs_n: 1'b1, vs_n: 1'b1};
		end else begin
			if (blank) begin
				board_video.r <= 4'd0;
				board_video.g <= 4'd0;
				board_video.b <= 4'd0;
			end else begin
				board_video.r <= line_odd ? dim(core_video.r, scanlines) : core_video.r;
				board_video.g <= line_odd ? dim(core_video.g, scanlines) : core_video.g;
				board_video.b <= line_odd ? dim(core_video.b, scanlines) : core_video.b;
			end
			board_video.hs_n <= ~core_video.hs;
			board_video.vs_n <= ~core_video.vs;
		end
	end

endmodule

`default_nettype wire

//--- source/audio_dac.sv
`timescale 1ns/1ps
`default_nettype none

`include "shell_defs.svh"

module audio_dac (
	input  wire                                clk_72,
	input  wire                                arst_n,
	input  wire signed [`SHELL_DAC_WIDTH-1:0]  sample,
	output logic                               dac
);

	localparam int W = `SHELL_DAC_WIDTH;

	logic [W-1:0] acc;
	logic [W-1:0] offset;
	logic [W:0]   sum;

	// Flipping the sign bit maps the signed range onto offset binary
	assign offset = {~sample[W-1], sample[W-2:0]};
	assign sum    = {1'b0, acc} + {1'b0, offset};

	// First order modulator, the carry out is the bit stream
	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
			dac <= 1'b0;
		end else begin
			acc <= sum[W-1:0];
			dac <= sum[W];
		end
	end

endmodule

`default_nettype wire

//--- source/shell_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "shell_defs.svh"

module shell_top (
	input  wire                                clk_72,
	input  wire                                arst_n,
	input  wire shell_pkg::ioctl_t             ioctl,
	input  wire [63:0]                         status,
	input  wire [1:0]                          buttons,
	input  wire [31:0]                         joystick_0,
	input  wire [31:0]                         joystick_1,
	input  wire shell_pkg::core_video_t        core_video,
	input  wire signed [`SHELL_DAC_WIDTH-1:0]  audio_l,
	input  wire signed [`SHELL_DAC_WIDTH-1:0]  audio_r,
	input  wire [`SHELL_ROM_AW-1:0]            rom_rd_addr,
	output logic [15:0]                        rom_rd_data,
	output logic                               core_reset,
	output logic                               rom_loaded,
	output shell_pkg::player_t                 p1,
	output shell_pkg::player_t                 p2,
	output logic [15:0]                        coin,
	output logic [7:0]                         dsw1,
	output logic [6:0]                         dsw2,
	output shell_pkg::board_video_t            board_video,
	output logic                               dac_l,
	output logic                               dac_r
);

	shell_pkg::rom_wr_t rom_wr;
	logic               rom_credit;

	// ==============================
	// ROM download and store
	// ==============================
	download_ctrl u_download_ctrl (
		.clk_72       (clk_72),
		.arst_n       (arst_n),
		.ioctl        (ioctl),
		.status_reset (status[`SHELL_OPT_RESET]),
		.button_reset (buttons[1]),
		.credit       (rom_credit),
		.rom_wr       (rom_wr),
		.rom_loaded   (rom_loaded),
		.core_reset   (core_reset)
	);

	rom_store u_rom_store (
		.clk_72  (clk_72),
		.arst_n  (arst_n),
		.rom_wr  (rom_wr),
		.credit  (rom_credit),
		.rd_addr (rom_rd_addr),
		.rd_data (rom_rd_data)
	);

	// ==============================
	// Controls, video and audio
	// ==============================
	input_mapper u_input_mapper (
		.clk_72     (clk_72),
		.arst_n     (arst_n),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.p1         (p1),
		.p2         (p2),
		.coin       (coin),
		.dsw1       (dsw1),
		.dsw2       (dsw2)
	);

	video_out u_video_out (
		.clk_72      (clk_72),
		.arst_n      (arst_n),
		.core_video  (core_video),
		.scanlines   (status[`SHELL_OPT_SCAN_LO +: 2]),
		.board_video (board_video)
	);

	audio_dac u_dac_l (
		.clk_72 (clk_72),
		.arst_n (arst_n),
		.sample (audio_l),
		.dac    (dac_l)
	);

	audio_dac u_dac_r (
		.clk_72 (clk_72),
		.arst_n (arst_n),
		.sample (audio_r),
		.dac    (dac_r)
	);

endmodule

`default_nettype wire

//--- tests/tb_shell_checks.svh
`ifndef TB_SHELL_CHECKS_SVH
`define TB_SHELL_CHECKS_SVH

// ==============================
// Compare tasks
// ==============================
task automatic check_player(input string name, input shell_pkg::player_t actual,
		input shell_pkg::player_t expected);
	if (actual !== expected) begin
		$display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end_with_failure();
	end
endtask

task automatic check_video(input string name, input shell_pkg::board_video_t actual,
		input shell_pkg::board_video_t expected);
	if (actual !== expected) begin
		$display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end_with_failure();
	end
endtask

task automatic check_word(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
	if (actual !== expected) begin
		$display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end_with_failure();
	end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
	if (actual !== expected) begin
		$display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end_with_failure();
	end
endtask

// ==============================
// Stimulus helpers
// ==============================

// Called right after a rising edge or at time zero
task automatic apply_reset();
	arst_n <= 1'b0;
	repeat (4) @(posedge clk_72);
	arst_n <= 1'b1;
endtask

// One write strobe, then enough idle cycles to keep the hold queue short
task automatic send_rom_byte(input logic [24:0] addr, input logic [7:0] data);
	@(posedge clk_72);
	ioctl.addr <= addr;
	ioctl.dout <= data;
	ioctl.wr   <= 1'b1;
	@(posedge clk_72);
	ioctl.wr <= 1'b0;
	repeat (3) @(posedge clk_72);
endtask

task automatic pulse_hsync();
	@(posedge clk_72);
	core_video.hs <= 1'b1;
	@(posedge clk_72);
	core_video.hs <= 1'b0;
	@(negedge clk_72);
	check_bit("board_video.hs_n", board_video.hs_n, 1'b0);
endtask

task automatic pulse_vsync();
	@(posedge clk_72);
	core_video.vs <= 1'b1;
	@(posedge clk_72);
	core_video.vs <= 1'b0;
	@(negedge clk_72);
	check_bit("board_video.vs_n", board_video.vs_n, 1'b0);
endtask

`endif

//--- tests/tb_shell.sv
`timescale 1ns/1ps
`default_nettype none

`include "shell_defs.svh"

module tb_shell;

	localparam int AW = `SHELL_ROM_AW;
	localparam int LOAD_CYCLES = (64 + 2) * 6 + 100;
	localparam int ROM_CYCLES = 32 * 3;
	localparam int INPUT_CYCLES = 4 * 3 * 3 + 10;
	localparam int VIDEO_CYCLES = 4 * 30 + 10;
	localparam int AUDIO_CYCLES = 5 * (1024 + 8);
	localparam int WATCHDOG_CYCLES =
		LOAD_CYCLES + ROM_CYCLES + INPUT_CYCLES + VIDEO_CYCLES + AUDIO_CYCLES + 1000;

	logic                            clk_72;
	logic                            arst_n;
	shell_pkg::ioctl_t               ioctl;
	logic [63:0]                     status;
	logic [1:0]                      buttons;
	logic [31:0]                     joystick_0;
	logic [31:0]                     joystick_1;
	shell_pkg::core_video_t          core_video;
	logic signed [`SHELL_DAC_WIDTH-1:0] audio_l;
	logic signed [`SHELL_DAC_WIDTH-1:0] audio_r;
	logic [AW-1:0]                   rom_rd_addr;
	logic [15:0]                     rom_rd_data;
	logic                            core_reset;
	logic                            rom_loaded;
	shell_pkg::player_t              p1;
	shell_pkg::player_t              p2;
	logic [15:0]                     coin;
	logic [7:0]                      dsw1;
	logic [6:0]                      dsw2;
	shell_pkg::board_video_t         board_video;
	logic                            dac_l;
	logic                            dac_r;

	integer     seed;
	logic [7:0] rom_bytes [64];
	int         credits_seen;

	shell_top i_dut (
		.clk_72      (clk_72),
		.arst_n      (arst_n),
		.ioctl       (ioctl),
		.status      (status),
		.buttons     (buttons),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.core_video  (core_video),
		.audio_l     (audio_l),
		.audio_r     (audio_r),
		.rom_rd_addr (rom_rd_addr),
		.rom_rd_data (rom_rd_data),
		.core_reset  (core_reset),
		.rom_loaded  (rom_loaded),
		.p1          (p1),
		.p2          (p2),
		.coin        (coin),
		.dsw1        (dsw1),
		.dsw2        (dsw2),
		.board_video (board_video),
		.dac_l       (dac_l),
		.dac_r       (dac_r)
	);

	task automatic end_with_failure();
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	`include "tb_shell_checks.svh"

	initial begin
		clk_72 = 1'b0;
		forever #10 clk_72 = ~clk_72;
	end

	// Every credit pulse marks one word written into the ROM memory
	initial credits_seen = 0;
	always @(posedge clk_72) begin
		if (i_dut.rom_credit) credits_seen <= credits_seen + 1;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_72);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		end_with_failure();
	end

	// ==============================
	// Expected values
	// ==============================

	// A quarter turn clockwise reports physical up as right, right as down and down as left
	function automatic shell_pkg::player_t expect_player(input logic [31:0] joy, input logic rot);
		shell_pkg::player_t p;
		p.start = ~joy[8];
		p.fire  = ~joy[6:4];
		p.right = rot ? ~joy[3] : ~joy[0];
		p.down  = rot ? ~joy[0] : ~joy[2];
		p.left  = rot ? ~joy[2] : ~joy[1];
		p.up    = rot ? ~joy[1] : ~joy[3];
		return p;
	endfunction

	function automatic logic [15:0] expect_coin(input logic [31:0] s1, input logic [31:0] s2,
			input logic service);
		logic tilt;
		tilt = s1[10] | s2[10];
		return {11'h7ff, ~tilt, ~service, ~s1[7], ~s1[9], ~s2[9]};
	endfunction

	task automatic check_pixel(input logic [3:0] r, input logic [3:0] g, input logic [3:0] b,
			input logic hb, input logic vb, input logic odd, input int s);
		shell_pkg::board_video_t exp;
		@(posedge clk_72);
		core_video.r  <= r;
		core_video.g  <= g;
		core_video.b  <= b;
		core_video.hb <= hb;
		core_video.vb <= vb;
		@(posedge clk_72);
		@(negedge clk_72);
		exp.hs_n = 1'b1;
		exp.vs_n = 1'b1;
		exp.r = (hb || vb) ? 4'd0 : odd ? 4'((int'(r) * (4 - s)) / 4) : r;
		exp.g = (hb || vb) ? 4'd0 : odd ? 4'((int'(g) * (4 - s)) / 4) : g;
		exp.b = (hb || vb) ? 4'd0 : odd ? 4'((int'(b) * (4 - s)) / 4) : b;
		check_video("board_video", board_video, exp);
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic test_load();
		int waited;
		waited = 0;
		@(negedge clk_72);
		check_bit("core_reset", core_reset, 1'b1);
		check_bit("rom_loaded", rom_loaded, 1'b0);
		@(posedge clk_72);
		ioctl.download <= 1'b1;
		ioctl.index    <= 8'd0;
		for (int i = 0; i < 64; i++) begin
			send_rom_byte(25'(i), rom_bytes[i]);
			@(negedge clk_72);
			check_bit("core_reset", core_reset, 1'b1);
		end
		@(posedge clk_72);
		ioctl.download <= 1'b0;
		repeat (2) @(posedge clk_72);
		@(negedge clk_72);
		check_bit("rom_loaded", rom_loaded, 1'b1);
		check_bit("core_reset", core_reset, 1'b0);
		while (credits_seen < 32 && waited < 200) begin
			@(negedge clk_72);
			waited++;
		end
		if (credits_seen < 32) begin
			$display("Only %0d of 32 ROM words were written to memory", credits_seen);
			end_with_failure();
		end
		@(posedge clk_72);
		status[`SHELL_OPT_RESET] <= 1'b1;
		@(posedge clk_72);
		@(negedge clk_72);
		check_bit("core_reset", core_reset, 1'b1);
		@(posedge clk_72);
		status[`SHELL_OPT_RESET] <= 1'b0;
		// A download with another index holds the core in reset and leaves the ROM alone
		@(posedge clk_72);
		ioctl.download <= 1'b1;
		ioctl.index    <= 8'd1;
		send_rom_byte(25'd0, ~rom_bytes[0]);
		send_rom_byte(25'd1, ~rom_bytes[1]);
		@(negedge clk_72);
		check_bit("core_reset", core_reset, 1'b1);
		check_bit("rom_loaded", rom_loaded, 1'b1);
		@(posedge clk_72);
		ioctl.download <= 1'b0;
		repeat (2) @(posedge clk_72);
		@(negedge clk_72);
		check_bit("core_reset", core_reset, 1'b0);
	endtask

	task automatic test_rom();
		for (int w = 0; w < 32; w++) begin
			@(posedge clk_72);
			rom_rd_addr <= AW'(w);
			@(posedge clk_72);
			@(negedge clk_72);
			check_word("rom_rd_data", rom_rd_data, {rom_bytes[2 * w + 1], rom_bytes[2 * w]});
		end
	endtask

	task automatic test_inputs();
		logic [31:0] pat_a [3];
		logic [31:0] pat_b [3];
		logic [31:0] s1;
		logic [31:0] s2;
		pat_a = '{32'h0000_0109, 32'h0000_00e2, 32'h0000_040c};
		pat_b = '{32'h0000_0214, 32'h0000_0001, 32'h0000_038a};
		@(posedge clk_72);
		status[`SHELL_OPT_DSW1_LO +: 8] <= 8'h5a;
		status[`SHELL_OPT_DSW2_LO +: 7] <= 7'h33;
		for (int opt = 0; opt < 4; opt++) begin
			for (int k = 0; k < 3; k++) begin
				@(posedge clk_72);
				status[`SHELL_OPT_JOYSWAP] <= opt[0];
				status[`SHELL_OPT_ROTATE]  <= opt[1];
				status[`SHELL_OPT_SERVICE] <= k[0];
				joystick_0 <= pat_a[k];
				joystick_1 <= pat_b[k];
				@(posedge clk_72);
				@(negedge clk_72);
				s1 = opt[0] ? pat_b[k] : pat_a[k];
				s2 = opt[0] ? pat_a[k] : pat_b[k];
				check_player("p1", p1, expect_player(s1, opt[1]));
				check_player("p2", p2, expect_player(s2, opt[1]));
				check_word("coin", coin, expect_coin(s1, s2, k[0]));
			end
		end
		check_word("dsw1", {8'h00, dsw1}, {8'h00, 8'ha5});
		check_word("dsw2", {9'h000, dsw2}, {9'h000, 7'h4c});
	endtask

	task automatic test_video();
		pulse_vsync();
		for (int s = 0; s < 4; s++) begin
			@(posedge clk_72);
			status[`SHELL_OPT_SCAN_LO +: 2] <= 2'(s);
			check_pixel(4'hf, 4'h9, 4'h6, 1'b0, 1'b0, 1'b0, s);
			pulse_hsync();
			check_pixel(4'hf, 4'h9, 4'h6, 1'b0, 1'b0, 1'b1, s);
			check_pixel(4'h3, 4'hb, 4'h1, 1'b0, 1'b0, 1'b1, s);
			check_pixel(4'hf, 4'hf, 4'hf, 1'b1, 1'b0, 1'b1, s);
			check_pixel(4'ha, 4'h7, 4'hc, 1'b0, 1'b1, 1'b1, s);
			// A new frame starts again on an even line
			pulse_vsync();
		end
	endtask

	// Ones over 1024 cycles follow from the offset binary value of the sample
	task automatic run_dac(input logic signed [15:0] l, input logic signed [15:0] r);
		int ones_l;
		int ones_r;
		ones_l = 0;
		ones_r = 0;
		@(posedge clk_72);
		audio_l <= l;
		audio_r <= r;
		apply_reset();
		repeat (1024) begin
			@(posedge clk_72);
			@(negedge clk_72);
			ones_l += int'(dac_l);
			ones_r += int'(dac_r);
		end
		check_word("dac_l ones", 16'(ones_l), 16'(((int'(l) + 32768) * 1024) / 65536));
		check_word("dac_r ones", 16'(ones_r), 16'(((int'(r) + 32768) * 1024) / 65536));
	endtask

	task automatic test_audio();
		run_dac(16'sh0000, 16'sh4000);
		run_dac(-16'sh6000, 16'sh7fff);
		run_dac(16'sh8000, 16'sh1234);
		run_dac(-16'sh0001, -16'sh7abc);
		run_dac(16'sh0123, 16'sh0000);
	endtask

	task automatic fill_rom_bytes();
		integer r;
		for (int i = 0; i < 64; i++) begin
			r = $random(seed);
			rom_bytes[i] = r[7:0];
		end
	endtask

	initial begin
		seed        = 32'h8aff_4212;
		arst_n      = 1'b0;
		ioctl       = '0;
		status      = '0;
		buttons     = '0;
		joystick_0  = '0;
		joystick_1  = '0;
		core_video  = '0;
		audio_l     = '0;
		audio_r     = '0;
		rom_rd_addr = '0;
		fill_rom_bytes();
		apply_reset();
		test_load();
		test_rom();
		test_inputs();
		test_video();
		test_audio();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
+incdir+tests
source/shell_pkg.sv
source/download_ctrl.sv
source/rom_store.sv
source/input_mapper.sv
source/video_out.sv
source/audio_dac.sv
source/shell_top.sv
tests/tb_shell.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_shell
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
